// ==== vlog.f ====
soc_pkg.sv
reset_sync.sv
bus_mem.sv
led_regs.sv
led_blinker.sv
soc_top.sv
soc_top_assert.sv
tb_soc_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_soc_top \
  --Mdir obj_dir \
  -o tb_soc_top

./obj_dir/tb_soc_top | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log || grep -q "%Error" sim.log; then
  echo "run failed"
  exit 1
fi

echo "run passed"

// ==== tb_soc_top.sv ====
`timescale 1ns/1ps

module tb_soc_top;

  import soc_pkg::*;

  // table operations
  localparam int op_wr = 0;
  localparam int op_rd = 1;
  localparam int op_wr_led = 2;
  localparam int op_noack = 3;
  localparam int op_blink = 4;
  localparam int op_steady = 5;

  localparam int n_words = 16;
  localparam int blink_p = 5;
  localparam int blink_toggles = 4;
  localparam int blink_cycles = (blink_toggles + 2) * blink_p + 8;

  logic              clk = 1'b0;
  logic              arst;
  logic              bus_req;
  logic              bus_write;
  logic [bus_aw-1:0] bus_addr;
  logic [bus_dw-1:0] bus_data_wr;
  logic              bus_ack;
  logic [bus_dw-1:0] bus_data_rd;
  logic [led_w-1:0]  led;
  logic              rst;

  // one row per bus operation or LED observation
  int          row_op[$];
  logic [31:0] row_addr[$];
  logic [31:0] row_wdata[$];
  logic [31:0] row_exp[$];

  logic [31:0] model_mem [0:mem_words-1];
  integer      seed;
  int          errors = 0;
  int          checks = 0;
  bit          table_ready = 1'b0;

  soc_top dut0 (
    .clk         (clk),
    .arst        (arst),
    .bus_req     (bus_req),
    .bus_write   (bus_write),
    .bus_addr    (bus_addr),
    .bus_data_wr (bus_data_wr),
    .bus_ack     (bus_ack),
    .bus_data_rd (bus_data_rd),
    .led         (led),
    .rst         (rst)
  );

  bind soc_top soc_top_assert assert0 (
    .clk         (clk),
    .rst         (rst),
    .bus_req     (bus_req),
    .bus_ack     (bus_ack),
    .bus_data_rd (bus_data_rd)
  );

  always #2 clk = ~clk;

  task expect_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task require(input bit cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      errors++;
      $display("%s", what);
    end
  endtask

  task add_row(input int op, input logic [31:0] addr, input logic [31:0] wdata,
               input logic [31:0] exp);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_wdata.push_back(wdata);
    row_exp.push_back(exp);
  endtask

  task build_table();
    logic [mem_aw-1:0] idx [n_words];
    logic [31:0]       data;
    int                start;
    int                i;
    start = $random(seed) & 32'h3ff;
    // odd stride keeps the word indices distinct
    for (i = 0; i < n_words; i++)
    begin
      idx[i] = mem_aw'((start + i * 37) % mem_words);
      data = $random(seed);
      model_mem[idx[i]] = data;
      add_row(op_wr, {20'h0, idx[i], 2'b00}, data, 32'h0);
    end
    for (i = 0; i < n_words; i++)
      add_row(op_rd, {20'h0, idx[i], 2'b00}, 32'h0, model_mem[idx[i]]);
    // overwrite one word
    data = $random(seed);
    model_mem[idx[3]] = data;
    add_row(op_wr, {20'h0, idx[3], 2'b00}, data, 32'h0);
    add_row(op_rd, {20'h0, idx[3], 2'b00}, 32'h0, data);
    // unmapped request followed by a normal read
    add_row(op_noack, 32'h8000_0000, 32'h0, 32'h0);
    add_row(op_rd, {20'h0, idx[0], 2'b00}, 32'h0, model_mem[idx[0]]);
    // LED registers drop the upper write bits
    add_row(op_wr, 32'hC000_0004, 32'h0, 32'h0);
    add_row(op_wr_led, 32'hC000_0000, 32'h1234_56A5, 32'h0000_00A5);
    add_row(op_wr, 32'hC000_0008, 32'hABCD_1234, 32'h0);
    add_row(op_wr, 32'hC000_0004, 32'hFFFF_FF3C, 32'h0);
    add_row(op_rd, 32'hC000_0000, 32'h0, 32'h0000_00A5);
    add_row(op_rd, 32'hC000_0004, 32'h0, 32'h0000_003C);
    add_row(op_rd, 32'hC000_0008, 32'h0, 32'h0000_1234);
    add_row(op_rd, 32'hC000_000C, 32'h0, 32'h0);
    // blink the low nibble and then stop
    add_row(op_wr, 32'hC000_0008, 32'(blink_p), 32'h0);
    add_row(op_wr, 32'hC000_0004, 32'h0000_000F, 32'h0);
    add_row(op_blink, 32'h0, 32'(blink_p), 32'h0000_A50F);
    add_row(op_wr, 32'hC000_0008, 32'h0, 32'h0);
    add_row(op_steady, 32'h0, 32'(3 * blink_p), 32'h0000_00A5);
  endtask

  // one-cycle request that returns just after the edge capturing it
  task send_req(input bit wr, input logic [31:0] addr, input logic [31:0] wdata);
    @(posedge clk);
    #1;
    bus_req = 1'b1;
    bus_write = wr;
    bus_addr = addr;
    bus_data_wr = wdata;
    @(posedge clk);
    #1;
    bus_req = 1'b0;
    bus_write = 1'b0;
  endtask

  task measure_blink(input int p, input logic [7:0] val, input logic [7:0] msk);
    logic [7:0] last;
    int         run;
    int         t;
    bit         found;
    found = 1'b0;
    run = 0;
    last = led;
    // period write cleared the phase
    expect_value("led", 32'(last), 32'(val));
    while (!found && run < 2 * p + 4)
    begin
      @(posedge clk);
      #1;
      run++;
      found = ((led & msk) != (last & msk));
    end
    require(found, "masked LED bits never toggled");
    for (t = 0; t < blink_toggles && found; t++)
    begin
      last = led;
      run = 0;
      do
      begin
        @(posedge clk);
        #1;
        run++;
        expect_value("led", 32'(led & ~msk), 32'(val & ~msk));
      end
      while ((led & msk) == (last & msk) && run < 2 * p + 4);
      // each level lasts one half period
      expect_value("led hold cycles", 32'(run), 32'(p));
      expect_value("led", 32'(led & msk), 32'(~last & msk));
    end
  endtask

  task hold_steady(input int n, input logic [7:0] exp);
    int k;
    for (k = 0; k < n; k++)
    begin
      @(posedge clk);
      #1;
      expect_value("led", 32'(led), 32'(exp));
    end
  endtask

  task run_row(input int i);
    int k;
    case (row_op[i])
      op_wr, op_rd, op_wr_led:
      begin
        send_req(row_op[i] != op_rd, row_addr[i], row_wdata[i]);
        expect_value("bus_ack", 32'(bus_ack), 32'h0);
        @(posedge clk);
        #1;
        expect_value("bus_ack", 32'(bus_ack), 32'h1);
        if (row_op[i] == op_rd)
          expect_value("bus_data_rd", bus_data_rd, row_exp[i]);
        if (row_op[i] == op_wr_led)
          expect_value("led", 32'(led), row_exp[i]);
      end
      op_noack:
      begin
        send_req(1'b0, row_addr[i], 32'h0);
        for (k = 0; k < 6; k++)
        begin
          @(posedge clk);
          #1;
          require(!bus_ack, "unmapped address was acknowledged");
        end
      end
      op_blink:
        measure_blink(int'(row_wdata[i]), row_exp[i][15:8], row_exp[i][7:0]);
      op_steady:
        hold_steady(int'(row_wdata[i]), row_exp[i][7:0]);
      default:
        require(1'b0, "unknown table operation");
    endcase
  endtask

  // 3-cycle arst pulse with rst edges counted from the arst edges
  task reset_pulse(input bit expect_rise);
    int   n;
    int   rise_at;
    int   fall_at;
    logic prev_rst;
    rise_at = -1;
    fall_at = -1;
    n = 0;
    @(posedge clk);
    #1;
    arst = 1'b1;
    prev_rst = rst;
    while (fall_at < 0 && n < 16)
    begin
      @(posedge clk);
      #1;
      n++;
      bus_req = 1'b0;
      if (n == 3)
      begin
        arst = 1'b0;
        // this read is captured as rst rises and must never reach bus_ack
        bus_req = 1'b1;
        bus_write = 1'b0;
        bus_addr = led_base;
      end
      if (rst && rise_at < 0)
        rise_at = n;
      if (!rst && rise_at >= 0)
        fall_at = n;
      if (rst && prev_rst)
      begin
        expect_value("bus_ack", 32'(bus_ack), 32'h0);
        expect_value("led", 32'(led), 32'h0);
      end
      prev_rst = rst;
    end
    bus_req = 1'b0;
    require(fall_at > 0, "rst did not fall after the arst pulse");
    if (expect_rise)
      expect_value("rst rise delay", 32'(rise_at), 32'(rst_stages));
    expect_value("rst fall delay", 32'(fall_at - 3), 32'(rst_stages));
    expect_value("led", 32'(led), 32'h0);
  endtask

  initial
  begin
    int limit;
    wait (table_ready);
    limit = row_op.size() * 4 + 2 * blink_cycles + 100;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    int i;
    arst = 1'b1;
    bus_req = 1'b0;
    bus_write = 1'b0;
    bus_addr = '0;
    bus_data_wr = '0;
    seed = 32'hcdbe_63b5;
    build_table();
    table_ready = 1'b1;
    reset_pulse(1'b0);
    for (i = 0; i < row_op.size(); i++)
      run_row(i);
    // reset again while the LEDs are lit
    reset_pulse(1'b1);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== soc_top_assert.sv ====
`timescale 1ns/1ps

module soc_top_assert (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       bus_req,
  input  logic                       bus_ack,
  input  logic [soc_pkg::bus_dw-1:0] bus_data_rd
);

  // every ack answers a request two cycles back
  ack_after_req: assert property (
    @(posedge clk) disable iff (rst)
    $rose(bus_ack) |-> $past(bus_req, 2)
  )
  else
    $error("bus_ack rose without a bus_req two cycles earlier");

  // one cycle of grace while reset lands in the output flop
  no_ack_in_reset: assert property (
    @(posedge clk)
    rst && $past(rst) |-> !bus_ack
  )
  else
    $error("bus_ack high during reset");

  idle_data_zero: assert property (
    @(posedge clk) disable iff (rst)
    !bus_ack |-> bus_data_rd == '0
  )
  else
    $error("bus_data_rd nonzero without bus_ack");

endmodule

// ==== soc_top.sv ====
`timescale 1ns/1ps

module soc_top (
  input  logic                       clk,
  input  logic                       arst,
  input  logic                       bus_req,
  input  logic                       bus_write,
  input  logic [soc_pkg::bus_aw-1:0] bus_addr,
  input  logic [soc_pkg::bus_dw-1:0] bus_data_wr,
  output logic                       bus_ack,
  output logic [soc_pkg::bus_dw-1:0] bus_data_rd,
  output logic [soc_pkg::led_w-1:0]  led,
  output logic                       rst
);

  import soc_pkg::*;

  // per-slave responses
  logic                mem_ack;
  logic [bus_dw-1:0]   mem_data_rd;
  logic                led_ack;
  logic [bus_dw-1:0]   led_data_rd;

  // LED register block to blinker
  logic [led_w-1:0]    led_value;
  logic [led_w-1:0]    led_mask;
  logic [period_w-1:0] led_period;
  logic                led_period_wr;

  reset_sync rst_sync0 (
    .clk  (clk),
    .arst (arst),
    .rst  (rst)
  );

  // slaves zero their data when idle, so a plain OR merges them
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bus_ack <= 1'b0;
      bus_data_rd <= '0;
    end
    else
    begin
      bus_ack <= mem_ack | led_ack;
      bus_data_rd <= mem_data_rd | led_data_rd;
    end
  end

  bus_mem mem0 (
    .clk         (clk),
    .rst         (rst),
    .bus_req     (bus_req),
    .bus_write   (bus_write),
    .bus_addr    (bus_addr),
    .bus_data_wr (bus_data_wr),
    .ack         (mem_ack),
    .data_rd     (mem_data_rd)
  );

  led_regs led_regs0 (
    .clk         (clk),
    .rst         (rst),
    .bus_req     (bus_req),
    .bus_write   (bus_write),
    .bus_addr    (bus_addr),
    .bus_data_wr (bus_data_wr),
    .ack         (led_ack),
    .data_rd     (led_data_rd),
    .value       (led_value),
    .mask        (led_mask),
    .period      (led_period),
    .period_wr   (led_period_wr)
  );

  led_blinker led_blink0 (
    .clk       (clk),
    .rst       (rst),
    .value     (led_value),
    .mask      (led_mask),
    .period    (led_period),
    .period_wr (led_period_wr),
    .led       (led)
  );

endmodule

// ==== led_blinker.sv ====
`timescale 1ns/1ps

module led_blinker (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [soc_pkg::led_w-1:0]    value,
  input  logic [soc_pkg::led_w-1:0]    mask,
  input  logic [soc_pkg::period_w-1:0] period,
  input  logic                         period_wr,
  output logic [soc_pkg::led_w-1:0]    led
);

  import soc_pkg::*;

  logic [period_w-1:0] cnt_q;
  logic                phase_q;

  // half-period down-counter, phase flips on each natural reload
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cnt_q <= '0;
      phase_q <= 1'b0;
    end
    else if (period_wr)
    begin
      // restart from the new period
      cnt_q <= period;
      phase_q <= 1'b0;
    end
    else if (period == '0)
    begin
      cnt_q <= '0;
      phase_q <= 1'b0;
    end
    else if (cnt_q <= period_w'(1))
    begin
      cnt_q <= period;
      phase_q <= ~phase_q;
    end
    else
    begin
      cnt_q <= cnt_q - period_w'(1);
    end
  end

  // masked pins follow the phase
  always_ff @(posedge clk)
  begin
    if (rst)
      led <= '0;
    else
      led <= value ^ (mask & {led_w{phase_q}});
  end

endmodule

// ==== led_regs.sv ====
`timescale 1ns/1ps

module led_regs (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         bus_req,
  input  logic                         bus_write,
  input  logic [soc_pkg::bus_aw-1:0]   bus_addr,
  input  logic [soc_pkg::bus_dw-1:0]   bus_data_wr,
  output logic                         ack,
  output logic [soc_pkg::bus_dw-1:0]   data_rd,
  output logic [soc_pkg::led_w-1:0]    value,
  output logic [soc_pkg::led_w-1:0]    mask,
  output logic [soc_pkg::period_w-1:0] period,
  output logic                         period_wr
);

  import soc_pkg::*;

  logic                 hit;
  logic                 wr_en;
  logic [led_off_w-1:0] off;
  logic [bus_dw-1:0]    rd_d;
  logic [bus_dw-1:0]    rd_q;

  assign hit = (bus_addr[bus_aw-1:led_off_w] == led_base[bus_aw-1:led_off_w]);
  assign off = bus_addr[led_off_w-1:0];
  assign wr_en = bus_req && hit && bus_write;

  // read mux, holes in the region read as zero
  always_comb
  begin
    case (off)
      led_off_value:  rd_d = bus_dw'(value);
      led_off_mask:   rd_d = bus_dw'(mask);
      led_off_period: rd_d = bus_dw'(period);
      default:        rd_d = '0;
    endcase
  end

  // control registers and ack
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      value <= '0;
      mask <= '0;
      period <= '0;
      period_wr <= 1'b0;
      ack <= 1'b0;
    end
    else
    begin
      ack <= bus_req && hit;
      // pulse lines up with the new period value
      period_wr <= wr_en && (off == led_off_period);
      if (wr_en && off == led_off_value)
        value <= bus_data_wr[led_w-1:0];
      if (wr_en && off == led_off_mask)
        mask <= bus_data_wr[led_w-1:0];
      if (wr_en && off == led_off_period)
        period <= bus_data_wr[period_w-1:0];
    end
  end

  // read data captured at request time
  always_ff @(posedge clk)
  begin
    if (bus_req && hit)
      rd_q <= bus_write ? '0 : rd_d;
  end

  assign data_rd = ack ? rd_q : '0;

endmodule

// ==== bus_mem.sv ====
`timescale 1ns/1ps

module bus_mem (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       bus_req,
  input  logic                       bus_write,
  input  logic [soc_pkg::bus_aw-1:0] bus_addr,
  input  logic [soc_pkg::bus_dw-1:0] bus_data_wr,
  output logic                       ack,
  output logic [soc_pkg::bus_dw-1:0] data_rd
);

  import soc_pkg::*;

  logic              hit;
  logic [mem_aw-1:0] word_idx;
  logic [bus_dw-1:0] mem_q [0:mem_words-1];
  logic [bus_dw-1:0] rd_q;

  // region match on everything above word index and byte offset
  assign hit = (bus_addr[bus_aw-1:mem_aw+2] == mem_base[bus_aw-1:mem_aw+2]);

  assign word_idx = bus_addr[mem_aw+1:2];

  // storage and read port
  always_ff @(posedge clk)
  begin
    if (bus_req && hit)
    begin
      if (bus_write)
      begin
        mem_q[word_idx] <= bus_data_wr;
        rd_q <= '0;
      end
      else
      begin
        rd_q <= mem_q[word_idx];
      end
    end
  end

  // one cycle ack after a claimed request
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack <= 1'b0;
    end
    else
    begin
      ack <= bus_req && hit;
    end
  end

  // zero when idle so the top can OR the slaves together
  assign data_rd = ack ? rd_q : '0;

endmodule

// ==== reset_sync.sv ====
`timescale 1ns/1ps

module reset_sync (
  input  logic clk,
  input  logic arst,
  output logic rst
);

  import soc_pkg::*;

  // power up in reset until arst has been sampled low through the chain
  logic [rst_stages-1:0] sync_q = '1;

  always_ff @(posedge clk)
  begin
    sync_q <= {sync_q[rst_stages-2:0], arst};
  end

  // last stage drives the synchronous reset
  assign rst = sync_q[rst_stages-1];

endmodule

// ==== soc_pkg.sv ====
package soc_pkg;

  // shared bus widths
  localparam int bus_aw = 32;
  localparam int bus_dw = 32;

  // memory region, word addressed
  localparam logic [bus_aw-1:0] mem_base = 32'h0000_0000;
  localparam int mem_aw = 10;
  localparam int mem_words = 1 << mem_aw;

  // LED peripheral region
  localparam logic [bus_aw-1:0] led_base = 32'hC000_0000;

  // low address bits that select a register inside the LED region
  localparam int led_off_w = 4;
  localparam int led_w = 8;

  // LED register byte offsets
  localparam logic [led_off_w-1:0] led_off_value = 4'h0;
  localparam logic [led_off_w-1:0] led_off_mask = 4'h4;
  localparam logic [led_off_w-1:0] led_off_period = 4'h8;

  // blink half-period register width
  localparam int period_w = 16;

  // reset synchronizer depth
  localparam int rst_stages = 4;

endpackage
